// File: tb.f
hw/rx_dma_pkg.sv
hw/rx_stage_if.sv
hw/rx_frame_parser.sv
hw/rx_ring_writer.sv
hw/dma_wr_issuer.sv
hw/rx_stats.sv
hw/rx_dma_top.sv
verification/rx_dma_chk.sv
verification/rx_dma_tb.sv

// File: Makefile
# Verilator flow for the rx DMA testbench

VERILATOR ?= verilator
TOP       ?= rx_dma_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/rx_dma_tb.sv
// directed tests for rx_dma_top; ack delay is random per request; only configure while idle
`timescale 1ns/1ns
`default_nettype none

module rx_dma_tb;

   localparam logic [15:0] max_pkt     = 16'd1536;  // largest good frame
   localparam int          cycle_limit = 4000;

   logic        clk = 1'b0;
   logic        rst;
   logic [63:0] s_tdata;
   logic [7:0]  s_tstrb;
   logic        s_tvalid;
   logic        s_tlast;
   logic [15:0] s_tuser_len;
   logic        s_tready;
   logic        mem_wr_en;
   logic [15:0] mem_wr_addr;
   logic [63:0] mem_wr_data;
   logic [63:0] host_pkt_offset;
   logic [63:0] host_pkt_mask;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [63:0] wb_adr;
   logic [31:0] wb_dat;
   logic        wb_ack;
   logic [31:0] stat_word_cnt;
   logic [31:0] stat_pkt_cnt;
   logic [31:0] stat_drop_cnt;

   // expected and observed traffic
   logic [15:0] exp_wr_addr[$];
   logic [63:0] exp_wr_data[$];
   logic [63:0] exp_wb_adr[$];
   logic [31:0] exp_wb_dat[$];
   logic [15:0] got_wr_addr[$];
   logic [63:0] got_wr_data[$];
   logic [63:0] got_wb_adr[$];
   logic [31:0] got_wb_dat[$];

   logic [15:0] exp_local_tail;
   logic [63:0] exp_host_tail;
   integer      seed = 32'h45b5;
   int          tb_words;
   int          tb_frames;
   int          tb_drops;
   int          ack_max;
   int          ack_wait;
   int          cycles = 0;

   always #2 clk = ~clk;

   rx_dma_top rx_dma_top_inst (
      .clk             (clk),
      .rst             (rst),
      .s_tdata         (s_tdata),
      .s_tstrb         (s_tstrb),
      .s_tvalid        (s_tvalid),
      .s_tlast         (s_tlast),
      .s_tuser_len     (s_tuser_len),
      .s_tready        (s_tready),
      .mem_wr_en       (mem_wr_en),
      .mem_wr_addr     (mem_wr_addr),
      .mem_wr_data     (mem_wr_data),
      .host_pkt_offset (host_pkt_offset),
      .host_pkt_mask   (host_pkt_mask),
      .wb_cyc          (wb_cyc),
      .wb_stb          (wb_stb),
      .wb_we           (wb_we),
      .wb_adr          (wb_adr),
      .wb_dat          (wb_dat),
      .wb_ack          (wb_ack),
      .stat_word_cnt   (stat_word_cnt),
      .stat_pkt_cnt    (stat_pkt_cnt),
      .stat_drop_cnt   (stat_drop_cnt)
   );

   // ------------------------------------------------------------
   // monitors, timeout and host write queue
   // ------------------------------------------------------------
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles == cycle_limit) begin
         $display("ERROR: run still busy after %0d cycles, giving up", cycle_limit);
         $display("Result: FAILED");
         $fatal(1, "timeout");
      end
   end

   always @(negedge clk) begin
      if (!rst && mem_wr_en) begin
         got_wr_addr.push_back(mem_wr_addr);   // write lands on next rising edge
         got_wr_data.push_back(mem_wr_data);
      end
   end

   always @(negedge clk) begin
      if (!rst && wb_cyc && wb_stb) begin
         check_eq(64'(wb_we), 64'd1, "wb_we in wishbone cycle");
         got_wb_adr.push_back(wb_adr);
         got_wb_dat.push_back(wb_dat);
         ack_wait = $unsigned($random(seed)) % (ack_max + 1);
         repeat (ack_wait) @(posedge clk);
         @(posedge clk);
         #1 wb_ack = 1'b1;
         @(posedge clk);
         #1 wb_ack = 1'b0;
      end
   end

   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
         $display("Result: FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   // ------------------------------------------------------------
   // stimulus and reference model
   // ------------------------------------------------------------
   task automatic send_word(input logic [63:0] data, input logic [7:0] strb,
                            input logic last, input logic [15:0] len);
      logic taken;
      s_tdata     = data;
      s_tstrb     = strb;
      s_tlast     = last;
      s_tuser_len = len;
      s_tvalid    = 1'b1;
      taken       = 1'b0;
      while (!taken) begin
         taken = s_tready;   // stable one ns after the edge
         @(posedge clk);
         #1;
      end
      tb_words++;
      if (last) begin
         tb_frames++;
      end
   endtask

   task automatic send_frame(input int nwords, input logic [7:0] last_strb,
                             input logic [15:0] len);
      logic [63:0] data;
      logic [7:0]  strb;
      logic [15:0] start;
      logic [15:0] nbytes;
      logic [15:0] aligned;
      logic        good;
      good   = (len != 16'd0) && (len <= max_pkt);
      start  = exp_local_tail;
      nbytes = 16'd0;
      for (int i = 0; i < nwords; i++) begin
         data = {$random(seed), $random(seed)};
         strb = (i == nwords - 1) ? last_strb : 8'hff;
         send_word(data, strb, i == nwords - 1, len);
         if (good) begin
            for (int b = 0; b < 8; b++) begin
               if (strb[b]) begin
                  nbytes = nbytes + 16'd1;
               end
               else begin
                  data[8*b +: 8] = 8'h00;   // stored zeroed past the strobe
               end
            end
            exp_wr_addr.push_back(start + 16'(8 * i));
            exp_wr_data.push_back(data);
         end
      end
      s_tvalid = 1'b0;
      s_tlast  = 1'b0;
      if (good) begin
         // next start rounds up to 64 bytes in both rings
         aligned = (nbytes + 16'd63) & ~16'd63;
         exp_wb_adr.push_back(host_pkt_offset + exp_host_tail);
         exp_wb_dat.push_back({nbytes, start});
         exp_local_tail = start + aligned;
         exp_host_tail  = (exp_host_tail + {48'd0, aligned}) & host_pkt_mask;
      end
      else begin
         tb_drops++;
      end
   endtask

   task automatic compare_outputs();
      while (got_wr_addr.size() < exp_wr_addr.size() ||
             got_wb_adr.size() < exp_wb_adr.size() || wb_cyc) begin
         @(negedge clk);
      end
      repeat (8) @(negedge clk);   // let any stray write show up
      check_eq(64'(got_wr_addr.size()), 64'(exp_wr_addr.size()), "memory write count");
      check_eq(64'(got_wb_adr.size()), 64'(exp_wb_adr.size()), "wishbone write count");
      for (int i = 0; i < exp_wr_addr.size(); i++) begin
         check_eq(64'(got_wr_addr[i]), 64'(exp_wr_addr[i]), $sformatf("write %0d addr", i));
         check_eq(got_wr_data[i], exp_wr_data[i], $sformatf("write %0d data", i));
      end
      for (int i = 0; i < exp_wb_adr.size(); i++) begin
         check_eq(got_wb_adr[i], exp_wb_adr[i], $sformatf("request %0d wb_adr", i));
         check_eq(64'(got_wb_dat[i]), 64'(exp_wb_dat[i]), $sformatf("request %0d wb_dat", i));
      end
      check_eq(64'(stat_word_cnt), 64'(tb_words), "stat_word_cnt");
      check_eq(64'(stat_pkt_cnt), 64'(tb_frames), "stat_pkt_cnt");
      check_eq(64'(stat_drop_cnt), 64'(tb_drops), "stat_drop_cnt");
      exp_wr_addr.delete();
      exp_wr_data.delete();
      exp_wb_adr.delete();
      exp_wb_dat.delete();
      got_wr_addr.delete();
      got_wr_data.delete();
      got_wb_adr.delete();
      got_wb_dat.delete();
      @(posedge clk);
      #1;
   endtask

   // ------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------
   task automatic test_full_packet();
      send_frame(8, 8'hff, 16'd64);   // local 0, host at offset
      compare_outputs();
   endtask

   task automatic test_partial_last();
      send_frame(4, 8'h07, 16'd27);
      send_frame(1, 8'h0f, 16'd4);    // single word is a good packet
      compare_outputs();
   endtask

   task automatic test_host_wrap();
      host_pkt_offset = 64'h0000_0001_0000_0000;
      host_pkt_mask   = 64'hff;      // 256-byte host ring
      send_frame(13, 8'h0f, 16'd100);
      send_frame(8, 8'hff, 16'd64);
      send_frame(17, 8'h03, 16'd130);
      send_frame(2, 8'hff, 16'd16);
      compare_outputs();
   endtask

   task automatic test_bad_frames();
      send_frame(3, 8'hff, 16'd0);
      send_frame(4, 8'h0f, 16'd2000);
      send_frame(1, 8'h01, 16'd1537);
      send_frame(2, 8'hff, 16'd16);   // parser back in step
      compare_outputs();
   endtask

   task automatic test_slow_ack();
      int         nwords;
      logic [7:0] strb;
      ack_max       = 20;
      host_pkt_mask = 64'hffff;
      for (int p = 0; p < 8; p++) begin
         nwords = 1 + ($unsigned($random(seed)) % 12);
         strb   = 8'hff >> ($unsigned($random(seed)) % 8);
         send_frame(nwords, strb, 16'(nwords * 8));
      end
      compare_outputs();
   endtask

   initial begin
      rst             = 1'b1;
      s_tdata         = '0;
      s_tstrb         = '0;
      s_tvalid        = 1'b0;
      s_tlast         = 1'b0;
      s_tuser_len     = '0;
      wb_ack          = 1'b0;
      host_pkt_offset = 64'h0000_0000_8000_0000;
      host_pkt_mask   = '1;
      ack_max         = 2;
      exp_local_tail  = '0;
      exp_host_tail   = '0;
      tb_words        = 0;
      tb_frames       = 0;
      tb_drops        = 0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      test_full_packet();
      test_partial_last();
      test_host_wrap();
      test_bad_frames();
      test_slow_ack();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/rx_dma_chk.sv
// protocol assertions bound into every rx_dma_top; reset must be held for at least one cycle
`timescale 1ns/1ns
`default_nettype none

module rx_dma_chk (
   input logic        clk,
   input logic        rst,
   input logic        s_tready,
   input logic [15:0] mem_wr_addr,
   input logic        wb_cyc,
   input logic        wb_stb,
   input logic        wb_ack,
   input logic [63:0] wb_adr,
   input logic [31:0] wb_dat
);

   // ------------------------------------------------------------
   // wishbone classic master
   // ------------------------------------------------------------
   // cycle closes the clock after the slave acks
   a_release_after_ack: assert property (@(posedge clk) disable iff (rst)
      (wb_stb && wb_ack) |=> (!wb_cyc && !wb_stb))
      else $error("wishbone cycle still open after wb_ack");

   // address and data frozen until the slave acks
   a_hold_until_ack: assert property (@(posedge clk) disable iff (rst)
      (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat)))
      else $error("wb_adr or wb_dat changed before wb_ack");

   // ------------------------------------------------------------
   // packet memory and stream side
   // ------------------------------------------------------------
   a_wr_aligned: assert property (@(posedge clk) disable iff (rst)
      mem_wr_addr[2:0] == 3'b000)
      else $error("mem_wr_addr not 8-byte aligned");

   a_no_ready_in_rst: assert property (@(posedge clk) rst |=> !s_tready)
      else $error("s_tready high during or right after reset");

endmodule

bind rx_dma_top rx_dma_chk rx_dma_chk_inst (
   .clk         (clk),
   .rst         (rst),
   .s_tready    (s_tready),
   .mem_wr_addr (mem_wr_addr),
   .wb_cyc      (wb_cyc),
   .wb_stb      (wb_stb),
   .wb_ack      (wb_ack),
   .wb_adr      (wb_adr),
   .wb_dat      (wb_dat)
);

`default_nettype wire

// File: hw/rx_dma_top.sv
// rx DMA top; no ring space checks, the host must keep up with the ring tails it is sent
`timescale 1ns/1ns
`default_nettype none

module rx_dma_top (
   input  logic                               clk,
   input  logic                               rst,
   // stream from the MAC
   input  logic [rx_dma_pkg::data_w-1:0]      s_tdata,
   input  logic [rx_dma_pkg::strb_w-1:0]      s_tstrb,
   input  logic                               s_tvalid,
   input  logic                               s_tlast,
   input  logic [rx_dma_pkg::len_w-1:0]       s_tuser_len,
   output logic                               s_tready,
   // local packet ring
   output logic                               mem_wr_en,
   output logic [rx_dma_pkg::mem_addr_w-1:0]  mem_wr_addr,
   output logic [rx_dma_pkg::data_w-1:0]      mem_wr_data,
   // host ring configuration
   input  logic [rx_dma_pkg::host_addr_w-1:0] host_pkt_offset,
   input  logic [rx_dma_pkg::host_addr_w-1:0] host_pkt_mask,
   // host write queue
   output logic                               wb_cyc,
   output logic                               wb_stb,
   output logic                               wb_we,
   output logic [rx_dma_pkg::host_addr_w-1:0] wb_adr,
   output logic [rx_dma_pkg::wb_dat_w-1:0]    wb_dat,
   input  logic                               wb_ack,
   // statistics
   output logic [rx_dma_pkg::cnt_w-1:0]       stat_word_cnt,
   output logic [rx_dma_pkg::cnt_w-1:0]       stat_pkt_cnt,
   output logic [rx_dma_pkg::cnt_w-1:0]       stat_drop_cnt
);

   logic drop_pulse;

   pkt_word_if word_if ();
   dma_req_if  req_if ();

   // ------------------------------------------------------------
   // pipeline stages
   // ------------------------------------------------------------
   rx_frame_parser rx_frame_parser_inst (
      .clk         (clk),
      .rst         (rst),
      .s_tdata     (s_tdata),
      .s_tstrb     (s_tstrb),
      .s_tvalid    (s_tvalid),
      .s_tlast     (s_tlast),
      .s_tuser_len (s_tuser_len),
      .s_tready    (s_tready),
      .drop_pulse  (drop_pulse),
      .word        (word_if.parser)
   );

   rx_ring_writer rx_ring_writer_inst (
      .clk             (clk),
      .rst             (rst),
      .host_pkt_offset (host_pkt_offset),
      .host_pkt_mask   (host_pkt_mask),
      .mem_wr_en       (mem_wr_en),
      .mem_wr_addr     (mem_wr_addr),
      .mem_wr_data     (mem_wr_data),
      .word            (word_if.writer),
      .req             (req_if.writer)
   );

   dma_wr_issuer dma_wr_issuer_inst (
      .clk    (clk),
      .rst    (rst),
      .wb_ack (wb_ack),
      .wb_cyc (wb_cyc),
      .wb_stb (wb_stb),
      .wb_we  (wb_we),
      .wb_adr (wb_adr),
      .wb_dat (wb_dat),
      .req    (req_if.issuer)
   );

   rx_stats rx_stats_inst (
      .clk           (clk),
      .rst           (rst),
      .s_tvalid      (s_tvalid),
      .s_tready      (s_tready),
      .s_tlast       (s_tlast),
      .drop_pulse    (drop_pulse),
      .stat_word_cnt (stat_word_cnt),
      .stat_pkt_cnt  (stat_pkt_cnt),
      .stat_drop_cnt (stat_drop_cnt)
   );

endmodule

`default_nettype wire

// File: hw/rx_stats.sv
// counters wrap silently; packet count includes dropped frames
`timescale 1ns/1ns
`default_nettype none

module rx_stats (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         s_tvalid,
   input  logic                         s_tready,
   input  logic                         s_tlast,
   input  logic                         drop_pulse,
   output logic [rx_dma_pkg::cnt_w-1:0] stat_word_cnt,
   output logic [rx_dma_pkg::cnt_w-1:0] stat_pkt_cnt,
   output logic [rx_dma_pkg::cnt_w-1:0] stat_drop_cnt
);

   logic accept;

   assign accept = s_tvalid & s_tready;

   always_ff @(posedge clk) begin
      if (rst) begin
         stat_word_cnt <= '0;
         stat_pkt_cnt  <= '0;
         stat_drop_cnt <= '0;
      end
      else begin
         if (accept) begin
            stat_word_cnt <= stat_word_cnt + 1'b1;
         end
         if (accept && s_tlast) begin
            stat_pkt_cnt <= stat_pkt_cnt + 1'b1;   // any frame end
         end
         if (drop_pulse) begin
            stat_drop_cnt <= stat_drop_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/dma_wr_issuer.sv
// one Wishbone classic write per request, no retry or error handling, we held high with cyc
`timescale 1ns/1ns
`default_nettype none

module dma_wr_issuer (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               wb_ack,
   output logic                               wb_cyc,
   output logic                               wb_stb,
   output logic                               wb_we,
   output logic [rx_dma_pkg::host_addr_w-1:0] wb_adr,
   output logic [rx_dma_pkg::wb_dat_w-1:0]    wb_dat,
   dma_req_if.issuer                          req
);

   rx_dma_pkg::issue_state_t state, state_nxt;
   logic                     accept;
   logic                     busy;

   // ------------------------------------------------------------
   // request intake
   // ------------------------------------------------------------
   assign req.ready = (state == rx_dma_pkg::issue_idle);
   assign accept    = req.valid & req.ready;
   assign busy      = (state == rx_dma_pkg::issue_busy);

   always_comb begin
      state_nxt = state;
      case (state)
         rx_dma_pkg::issue_idle: begin
            if (accept) begin
               state_nxt = rx_dma_pkg::issue_busy;
            end
         end
         rx_dma_pkg::issue_busy: begin
            if (wb_ack) begin
               state_nxt = rx_dma_pkg::issue_idle;   // strobes fall next cycle
            end
         end
         default: state_nxt = rx_dma_pkg::issue_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= rx_dma_pkg::issue_idle;
      end
      else begin
         state <= state_nxt;
      end
   end

   // ------------------------------------------------------------
   // wishbone master
   // ------------------------------------------------------------
   assign wb_cyc = busy;
   assign wb_stb = busy;
   assign wb_we  = busy;

   // address and data only load while idle, so they hold until ack
   always_ff @(posedge clk) begin
      if (accept) begin
         wb_adr <= req.host_addr;
         wb_dat <= {req.len, req.local_addr};   // len high, local address low
      end
   end

endmodule

`default_nettype wire

// File: hw/rx_ring_writer.sv
// host_pkt_mask must be a power of two minus one with its low 6 bits set; offset 64-byte aligned
`timescale 1ns/1ns
`default_nettype none

module rx_ring_writer (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [rx_dma_pkg::host_addr_w-1:0] host_pkt_offset,
   input  logic [rx_dma_pkg::host_addr_w-1:0] host_pkt_mask,
   output logic                               mem_wr_en,
   output logic [rx_dma_pkg::mem_addr_w-1:0]  mem_wr_addr,
   output logic [rx_dma_pkg::data_w-1:0]      mem_wr_data,
   pkt_word_if.writer                         word,
   dma_req_if.writer                          req
);

   logic                               xfer;
   logic                               pkt_end;
   logic [rx_dma_pkg::mem_addr_w-1:0]  local_tail;   // next word address
   logic [rx_dma_pkg::mem_addr_w-1:0]  pkt_start;
   logic [rx_dma_pkg::mem_addr_w-1:0]  start_addr;
   logic [rx_dma_pkg::host_addr_w-1:0] host_tail;    // host offset of current packet
   logic [rx_dma_pkg::len_w-1:0]       byte_cnt;
   logic [rx_dma_pkg::len_w-1:0]       word_bytes;
   logic [rx_dma_pkg::len_w-1:0]       pkt_bytes;
   logic [rx_dma_pkg::len_w-1:0]       aligned_len;

   // only a last word needs the request register free
   assign word.ready = ~word.last | ~req.valid | req.ready;
   assign xfer       = word.valid & word.ready;
   assign pkt_end    = xfer & word.last;

   assign mem_wr_en   = xfer;
   assign mem_wr_addr = local_tail;
   assign mem_wr_data = word.data;

   // ------------------------------------------------------------
   // packet length and start
   // ------------------------------------------------------------
   assign start_addr  = word.first ? local_tail : pkt_start;   // single-word packets too
   assign word_bytes  = {{(rx_dma_pkg::len_w - rx_dma_pkg::nbytes_w){1'b0}}, word.nbytes};
   assign pkt_bytes   = (word.first ? '0 : byte_cnt) + word_bytes;
   assign aligned_len = (pkt_bytes + rx_dma_pkg::align_mask) & ~rx_dma_pkg::align_mask;

   always_ff @(posedge clk) begin
      if (rst) begin
         local_tail <= '0;
         host_tail  <= '0;
         byte_cnt   <= '0;
         req.valid  <= 1'b0;
      end
      else begin
         if (xfer) begin
            byte_cnt <= pkt_bytes;
            if (word.last) begin
               // next packet starts on a 64-byte boundary in both rings
               local_tail <= start_addr + aligned_len;
               host_tail  <= (host_tail +
                              {{(rx_dma_pkg::host_addr_w - rx_dma_pkg::len_w){1'b0}},
                               aligned_len}) & host_pkt_mask;
            end
            else begin
               local_tail <= local_tail + rx_dma_pkg::word_step;
            end
         end
         if (pkt_end) begin
            req.valid <= 1'b1;
         end
         else if (req.ready) begin
            req.valid <= 1'b0;
         end
      end
      if (xfer && word.first) begin
         pkt_start <= local_tail;
      end
      if (pkt_end) begin
         req.local_addr <= start_addr;
         req.host_addr  <= host_pkt_offset + host_tail;
         req.len        <= pkt_bytes;
      end
   end

endmodule

`default_nettype wire

// File: hw/rx_frame_parser.sv
// length in tuser is checked on the first word only; last-word strobe must be contiguous from byte 0
`timescale 1ns/1ns
`default_nettype none

module rx_frame_parser (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [rx_dma_pkg::data_w-1:0]   s_tdata,
   input  logic [rx_dma_pkg::strb_w-1:0]   s_tstrb,
   input  logic                            s_tvalid,
   input  logic                            s_tlast,
   input  logic [rx_dma_pkg::len_w-1:0]    s_tuser_len,
   output logic                            s_tready,
   output logic                            drop_pulse,
   pkt_word_if.parser                      word
);

   rx_dma_pkg::parse_state_t            state, state_nxt;
   logic                                armed;      // low through reset and one cycle after
   logic                                accept;
   logic                                len_bad;
   logic                                load;
   logic                                drop_end;
   logic [rx_dma_pkg::data_w-1:0]       trim_data;
   logic [rx_dma_pkg::nbytes_w-1:0]     trim_nbytes;

   // room in the output register, or it empties this cycle
   assign s_tready = armed & (~word.valid | word.ready);
   assign accept   = s_tvalid & s_tready;
   assign len_bad  = (s_tuser_len == '0) || (s_tuser_len > rx_dma_pkg::max_pkt_bytes);

   // bad frame ends here, either single-word or from parse_drop
   assign drop_end = accept & s_tlast &
                     (((state == rx_dma_pkg::parse_idle) & len_bad) |
                      (state == rx_dma_pkg::parse_drop));

   // ------------------------------------------------------------
   // frame FSM
   // ------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      load      = 1'b0;
      case (state)
         rx_dma_pkg::parse_idle: begin
            if (accept && len_bad && !s_tlast) begin
               state_nxt = rx_dma_pkg::parse_drop;
            end
            else if (accept && !len_bad) begin
               load = 1'b1;
               if (!s_tlast) begin
                  state_nxt = rx_dma_pkg::parse_data;
               end
            end
         end
         rx_dma_pkg::parse_data: begin
            if (accept) begin
               load = 1'b1;
               if (s_tlast) begin
                  state_nxt = rx_dma_pkg::parse_idle;
               end
            end
         end
         rx_dma_pkg::parse_drop: begin
            if (accept && s_tlast) begin
               state_nxt = rx_dma_pkg::parse_idle;
            end
         end
         default: state_nxt = rx_dma_pkg::parse_idle;
      endcase
   end

   // ------------------------------------------------------------
   // last-word trim
   // ------------------------------------------------------------
   always_comb begin
      trim_data   = s_tdata;
      trim_nbytes = rx_dma_pkg::full_nbytes;      // inner words are always full
      if (s_tlast) begin
         trim_nbytes = '0;
         for (int i = 0; i < rx_dma_pkg::strb_w; i++) begin
            if (s_tstrb[i]) begin
               trim_nbytes = trim_nbytes + 1'b1;
            end
            else begin
               trim_data[8*i +: 8] = 8'h00;    // clear bytes past the strobe
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= rx_dma_pkg::parse_idle;
         armed      <= 1'b0;
         drop_pulse <= 1'b0;
         word.valid <= 1'b0;
      end
      else begin
         state      <= state_nxt;
         armed      <= 1'b1;
         drop_pulse <= drop_end;
         if (load) begin
            word.valid <= 1'b1;
         end
         else if (word.ready) begin
            word.valid <= 1'b0;
         end
      end
      if (load) begin
         word.data   <= trim_data;
         word.nbytes <= trim_nbytes;
         word.last   <= s_tlast;
         word.first  <= (state == rx_dma_pkg::parse_idle);
      end
   end

endmodule

`default_nettype wire

// File: hw/rx_stage_if.sv
// inter-stage links; a transfer happens on any cycle with valid and ready both high
`timescale 1ns/1ns
`default_nettype none

// ------------------------------------------------------------
// parser -> ring writer, one stream word per transfer
// ------------------------------------------------------------
interface pkt_word_if;
   logic                            valid;
   logic [rx_dma_pkg::data_w-1:0]   data;
   logic                            last;
   logic [rx_dma_pkg::nbytes_w-1:0] nbytes;  // valid bytes, from byte 0 up
   logic                            first;   // start of packet
   logic                            ready;

   modport parser (output valid, data, last, nbytes, first, input ready);
   modport writer (input valid, data, last, nbytes, first, output ready);
endinterface

// ------------------------------------------------------------
// ring writer -> issuer, one DMA write per packet
// ------------------------------------------------------------
interface dma_req_if;
   logic                               valid;
   logic [rx_dma_pkg::host_addr_w-1:0] host_addr;
   logic [rx_dma_pkg::mem_addr_w-1:0]  local_addr;
   logic [rx_dma_pkg::len_w-1:0]       len;
   logic                               ready;

   modport writer (output valid, host_addr, local_addr, len, input ready);
   modport issuer (input valid, host_addr, local_addr, len, output ready);
endinterface

`default_nettype wire

// File: hw/rx_dma_pkg.sv
// shared widths and limits; mem_addr_w must equal len_w, ring alignment must be a power of two
`default_nettype none

package rx_dma_pkg;

   // ------------------------------------------------------------
   // stream and packet sizes
   // ------------------------------------------------------------
   localparam int data_w   = 64;                   // MAC stream word
   localparam int strb_w   = 8;                    // one strobe bit per byte
   localparam int len_w    = 16;                   // length in tuser
   localparam int nbytes_w = $clog2(strb_w) + 1;   // holds 1..8

   localparam logic [len_w-1:0]    max_pkt_bytes = len_w'(1536);
   localparam logic [nbytes_w-1:0] full_nbytes   = nbytes_w'(strb_w);

   // ------------------------------------------------------------
   // ring geometry
   // ------------------------------------------------------------
   localparam int ring_align_bytes = 64;
   localparam int mem_addr_w       = 16;           // 64 KiB local ring, wraps on its own
   localparam int host_addr_w      = 64;

   // round-up mask for packet start alignment
   localparam logic [len_w-1:0] align_mask = len_w'(ring_align_bytes - 1);

   // local write pointer step, one stream word
   localparam logic [mem_addr_w-1:0] word_step = mem_addr_w'(strb_w);

   // ------------------------------------------------------------
   // host side
   // ------------------------------------------------------------
   localparam int wb_dat_w = len_w + mem_addr_w;   // {len, local_addr}
   localparam int cnt_w    = 32;                   // statistics counters

   // frame parser
   typedef enum logic [1:0] {
      parse_idle,    // waiting for the first word of a frame
      parse_data,    // passing a good frame on
      parse_drop     // discarding a bad frame up to tlast
   } parse_state_t;

   // write request issuer
   typedef enum logic {
      issue_idle,
      issue_busy     // wishbone cycle open, waiting for ack
   } issue_state_t;

endpackage

`default_nettype wire
